/* source/pacman_pkg.sv */
package pacman_pkg;

  ////////////////////////////////////////////////////////////
  // Map geometry
  localparam int map_cols   = 32;
  localparam int map_rows   = 36;
  localparam int vis_cols   = 28;
  localparam int tile_size  = 8;
  localparam int map_depth  = map_cols * map_rows;
  localparam int map_addr_w = 11;
  localparam int coord_w    = 9;
  // Pixel bits inside a tile, tile index bits above them
  localparam int tile_bits  = $clog2(tile_size);
  localparam int tile_idx_w = coord_w - tile_bits;

  // Tile contents as stored in the map RAM
  typedef enum logic [1:0] {
    tile_empty  = 2'd0,
    tile_wall   = 2'd1,
    tile_candy  = 2'd2,
    tile_cookie = 2'd3
  } tile_t;

  typedef enum logic [2:0] {
    dir_none  = 3'd0,
    dir_up    = 3'd1,
    dir_down  = 3'd2,
    dir_left  = 3'd3,
    dir_right = 3'd4
  } dir_t;

  ////////////////////////////////////////////////////////////
  // APB register map, byte addresses
  localparam int apb_addr_w = 4;
  localparam int apb_data_w = 32;

  typedef enum logic [3:0] {
    reg_score    = 4'd0,
    reg_cookies  = 4'd4,
    reg_ctrl     = 4'd8,
    reg_position = 4'd12
  } reg_addr_t;

  // 4 bits per channel, r in the top nibble
  localparam logic [11:0] col_wall   = 12'h00F;
  localparam logic [11:0] col_candy  = 12'hFFF;
  localparam logic [11:0] col_cookie = 12'hFBB;
  localparam logic [11:0] col_player = 12'hFF0;
  localparam logic [11:0] col_black  = 12'h000;

  // Linear RAM address of a tile
  function automatic logic [map_addr_w-1:0] tile_index(input logic [tile_idx_w-1:0] col,
                                                       input logic [tile_idx_w-1:0] row);
    return map_addr_w'(row * map_cols + col);
  endfunction

  // Power-up map, first matching rule wins
  function automatic tile_t initial_tile(input int col, input int row);
    // Border ring and the hidden columns past the playfield
    if (col == 0 || col == vis_cols - 1 || col >= vis_cols) return tile_wall;
    if (row == 0 || row == map_rows - 1) return tile_wall;
    // Centre divider
    if (col == 14 && row >= 10 && row <= 20) return tile_wall;
    // Four corner power cookies
    if ((col == 1 || col == vis_cols - 2) && (row == 1 || row == map_rows - 2)) begin
      return tile_cookie;
    end
    // Player start tile
    if (col == 13 && row == 26) return tile_empty;
    return tile_candy;
  endfunction

endpackage

/* source/map_port_if.sv */
`timescale 1ns/100ps

// Player side port of the tile map RAM
interface map_port_if import pacman_pkg::*; ();

  // Tile address, row * map_cols + col
  logic [map_addr_w-1:0] addr;
  // Tile at addr, one cycle late
  tile_t                 rd_tile;
  // Write strobe and data
  logic                  wr_en;
  tile_t                 wr_tile;

  // Movement engine side
  modport requester (
    output addr, wr_en, wr_tile,
    input  rd_tile
  );

  // RAM side
  modport memory (
    input  addr, wr_en, wr_tile,
    output rd_tile
  );

endinterface

/* source/tile_map_ram.sv */
`timescale 1ns/100ps

module tile_map_ram import pacman_pkg::*; (
  input  logic                  vga_pix_clk,
  input  logic                  rst,
  // Beam port, read only
  input  logic [map_addr_w-1:0] beam_addr,
  output tile_t                 beam_tile,
  // Player port, read and write
  map_port_if.memory            player
);

  // One word per tile, 32 columns per row
  tile_t mem [map_depth];

  ////////////////////////////////////////////////////////////
  // Power-up contents
  initial begin
    for (int row = 0; row < map_rows; row++) begin
      for (int col = 0; col < map_cols; col++) begin
        mem[row * map_cols + col] = initial_tile(col, row);
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Port a
  // Renderer reads, one cycle latency
  always_ff @(posedge vga_pix_clk) begin
    beam_tile <= mem[beam_addr];
  end

  ////////////////////////////////////////////////////////////
  // Port b
  // Read before write, so a same-cycle read sees the old tile
  always_ff @(posedge vga_pix_clk) begin
    if (player.wr_en) begin
      mem[player.addr] <= player.wr_tile;
    end
    player.rd_tile <= mem[player.addr];
  end

  // Writes land inside the map only
  a_wr_in_range: assert property (
    @(posedge vga_pix_clk) disable iff (rst)
    player.wr_en |-> (int'(player.addr) < map_depth)
  ) else $error("map write outside of the tile array");

endmodule

/* source/pacman_movement.sv */
`timescale 1ns/100ps

module pacman_movement import pacman_pkg::*; #(
  parameter int unsigned start_x = 104,
  parameter int unsigned start_y = 208
) (
  input  logic               vga_pix_clk,
  input  logic               rst,
  input  logic               frame_stb,
  input  logic               btn_up,
  input  logic               btn_down,
  input  logic               btn_left,
  input  logic               btn_right,
  input  logic               pause,
  output logic [coord_w-1:0] x_pac,
  output logic [coord_w-1:0] y_pac,
  output logic               ate_candy_stb,
  output logic               ate_cookie_stb,
  map_port_if.requester      map
);

  // One step per frame, five cycles after leaving idle
  typedef enum logic [2:0] {
    st_idle, st_probe, st_decide, st_move, st_check, st_clear
  } state_t;

  state_t       state;
  dir_t         dir;
  dir_t         btn_dir;
  dir_t         live_dir;
  dir_t         next_dir;
  tile_t        btn_tile;
  logic         aligned;
  logic         clear_en;

  // Highest priority pressed button, up first
  function automatic dir_t pick_button(input logic up, input logic down,
                                       input logic left, input logic right);
    if (up) return dir_up;
    if (down) return dir_down;
    if (left) return dir_left;
    if (right) return dir_right;
    return dir_none;
  endfunction

  // Address of the tile next to the player in direction d
  function automatic logic [map_addr_w-1:0] ahead_addr(input logic [coord_w-1:0] px,
                                                       input logic [coord_w-1:0] py,
                                                       input dir_t d);
    logic [tile_idx_w-1:0] col;
    logic [tile_idx_w-1:0] row;
    col = px[coord_w-1:tile_bits];
    row = py[coord_w-1:tile_bits];
    case (d)
      dir_up:    row = row - tile_idx_w'(1);
      dir_down:  row = row + tile_idx_w'(1);
      dir_left:  col = col - tile_idx_w'(1);
      dir_right: col = col + tile_idx_w'(1);
      default:   ;
    endcase
    return tile_index(col, row);
  endfunction

  assign aligned  = (x_pac[tile_bits-1:0] == '0) && (y_pac[tile_bits-1:0] == '0);
  assign live_dir = pick_button(btn_up, btn_down, btn_left, btn_right);

  ////////////////////////////////////////////////////////////
  // RAM port
  // Idle reads the button tile, probe the tile ahead, later the own tile
  always_comb begin
    case (state)
      st_idle:  map.addr = ahead_addr(x_pac, y_pac, live_dir);
      st_probe: map.addr = ahead_addr(x_pac, y_pac, dir);
      default:  map.addr = ahead_addr(x_pac, y_pac, dir_none);
    endcase
  end
  assign map.wr_en   = clear_en;
  assign map.wr_tile = tile_empty;

  // Direction choice, rd_tile holds the tile ahead in decide
  always_comb begin
    if (!aligned) next_dir = dir;
    else if (btn_dir != dir_none && btn_tile != tile_wall) next_dir = btn_dir;
    else if (dir != dir_none && map.rd_tile != tile_wall) next_dir = dir;
    else next_dir = dir_none;
  end

  ////////////////////////////////////////////////////////////
  // Step FSM
  always_ff @(posedge vga_pix_clk) begin
    if (rst) begin
      state          <= st_idle;
      dir            <= dir_none;
      btn_dir        <= dir_none;
      x_pac          <= coord_w'(start_x);
      y_pac          <= coord_w'(start_y);
      ate_candy_stb  <= 1'b0;
      ate_cookie_stb <= 1'b0;
      clear_en       <= 1'b0;
    end else begin
      // Strobes last one cycle
      ate_candy_stb  <= 1'b0;
      ate_cookie_stb <= 1'b0;
      clear_en       <= 1'b0;
      case (state)
        st_idle: begin
          if (frame_stb && !pause) begin
            btn_dir <= live_dir;
            state   <= st_probe;
          end
        end
        st_probe: begin
          btn_tile <= map.rd_tile;
          state    <= st_decide;
        end
        st_decide: begin
          dir <= next_dir;
          case (next_dir)
            dir_up:    y_pac <= y_pac - coord_w'(1);
            dir_down:  y_pac <= y_pac + coord_w'(1);
            dir_left:  x_pac <= x_pac - coord_w'(1);
            dir_right: x_pac <= x_pac + coord_w'(1);
            default:   ;
          endcase
          state <= st_move;
        end
        st_move: state <= st_check;
        st_check: begin
          // Eat whatever sits on the tile just reached
          if (aligned && map.rd_tile == tile_candy) begin
            ate_candy_stb <= 1'b1;
            clear_en      <= 1'b1;
          end
          if (aligned && map.rd_tile == tile_cookie) begin
            ate_cookie_stb <= 1'b1;
            clear_en       <= 1'b1;
          end
          state <= st_clear;
        end
        default: state <= st_idle;
      endcase
    end
  end

  a_one_eat: assert property (
    @(posedge vga_pix_clk) disable iff (rst) !(ate_candy_stb && ate_cookie_stb)
  ) else $error("candy and cookie eaten in the same cycle");

  a_wr_in_clear: assert property (
    @(posedge vga_pix_clk) disable iff (rst) map.wr_en |-> (state == st_clear)
  ) else $error("tile write outside of st_clear");

endmodule

/* source/score_regs.sv */
`timescale 1ns/100ps

module score_regs import pacman_pkg::*; (
  input  logic                  vga_pix_clk,
  input  logic                  rst,
  // APB slave
  input  logic                  psel,
  input  logic                  penable,
  input  logic                  pwrite,
  input  logic [apb_addr_w-1:0] paddr,
  input  logic [apb_data_w-1:0] pwdata,
  output logic [apb_data_w-1:0] prdata,
  output logic                  pready,
  output logic                  pslverr,
  // Game side
  input  logic [coord_w-1:0]    x_pac,
  input  logic [coord_w-1:0]    y_pac,
  input  logic                  ate_candy_stb,
  input  logic                  ate_cookie_stb,
  output logic                  pause
);

  logic [9:0] candy_cnt;
  logic [2:0] cookie_cnt;
  logic       access;
  reg_addr_t  reg_sel;

  // Zero wait, every access completes at once
  assign pready  = 1'b1;
  assign access  = psel && penable;
  assign reg_sel = reg_addr_t'(paddr);

  ////////////////////////////////////////////////////////////
  // Counters and control
  always_ff @(posedge vga_pix_clk) begin
    if (rst) begin
      candy_cnt  <= '0;
      cookie_cnt <= '0;
      pause      <= 1'b0;
    end else begin
      // Wrap at counter width
      if (ate_candy_stb) candy_cnt <= candy_cnt + 10'd1;
      if (ate_cookie_stb) cookie_cnt <= cookie_cnt + 3'd1;
      // Only ctrl is writable
      if (access && pwrite && reg_sel == reg_ctrl) pause <= pwdata[0];
    end
  end

  ////////////////////////////////////////////////////////////
  // Read data and error decode
  always_comb begin
    prdata  = '0;
    pslverr = 1'b0;
    if (access) begin
      case (reg_sel)
        reg_score: begin
          prdata  = apb_data_w'(candy_cnt);
          pslverr = pwrite;
        end
        reg_cookies: begin
          prdata  = apb_data_w'(cookie_cnt);
          pslverr = pwrite;
        end
        reg_ctrl: prdata = apb_data_w'(pause);
        reg_position: begin
          // x in bits 8..0, y in bits 24..16
          prdata[coord_w-1:0]     = x_pac;
          prdata[16+coord_w-1:16] = y_pac;
          pslverr                 = pwrite;
        end
        // Holes in the map
        default: pslverr = 1'b1;
      endcase
    end
  end

  // Setup is followed by an access that completes
  a_apb_access: assert property (
    @(posedge vga_pix_clk) disable iff (rst)
    (psel && !penable) |=> (psel && penable && pready)
  ) else $error("APB setup phase not followed by a completed access");

endmodule

/* source/tile_renderer.sv */
`timescale 1ns/100ps

module tile_renderer import pacman_pkg::*; (
  input  logic                  vga_pix_clk,
  input  logic                  rst,
  input  logic [coord_w-1:0]    sx,
  input  logic [coord_w-1:0]    sy,
  input  logic                  display_enabled,
  input  logic [coord_w-1:0]    x_pac,
  input  logic [coord_w-1:0]    y_pac,
  // Tile map port a
  output logic [map_addr_w-1:0] beam_addr,
  input  tile_t                 beam_tile,
  output logic [3:0]            r,
  output logic [3:0]            g,
  output logic [3:0]            b
);

  logic [tile_idx_w-1:0] tile_col;
  logic [tile_idx_w-1:0] tile_row;
  logic                  in_field;
  logic                  on_player;
  // Stage 1 registers
  logic                  en_q;
  logic                  field_q;
  logic                  player_q;
  logic [tile_bits-1:0]  off_x_q;
  logic [tile_bits-1:0]  off_y_q;
  logic [11:0]           colour;

  ////////////////////////////////////////////////////////////
  // Stage 1 beam to tile address
  assign tile_col  = sx[coord_w-1:tile_bits];
  assign tile_row  = sy[coord_w-1:tile_bits];
  assign beam_addr = tile_index(tile_col, tile_row);
  // Beam outside the 28x36 playfield shows no tiles
  assign in_field  = (int'(tile_col) < vis_cols) && (int'(tile_row) < map_rows);

  // Player square, one extra bit so x_pac + 8 cannot wrap
  assign on_player = ({1'b0, sx} >= {1'b0, x_pac}) &&
                     ({1'b0, sx} < {1'b0, x_pac} + (coord_w+1)'(tile_size)) &&
                     ({1'b0, sy} >= {1'b0, y_pac}) &&
                     ({1'b0, sy} < {1'b0, y_pac} + (coord_w+1)'(tile_size));

  always_ff @(posedge vga_pix_clk) begin
    if (rst) begin
      en_q <= 1'b0;
    end else begin
      en_q <= display_enabled;
    end
    field_q  <= in_field;
    player_q <= on_player;
    off_x_q  <= sx[tile_bits-1:0];
    off_y_q  <= sy[tile_bits-1:0];
  end

  ////////////////////////////////////////////////////////////
  // Stage 2 tile to colour
  // beam_tile arrives together with the stage 1 registers
  always_comb begin
    if (!en_q) colour = col_black;
    else if (player_q) colour = col_player;
    else if (!field_q) colour = col_black;
    else begin
      case (beam_tile)
        tile_wall: colour = col_wall;
        // Small dot in the tile centre
        tile_candy: begin
          if (off_x_q inside {[3:4]} && off_y_q inside {[3:4]}) colour = col_candy;
          else colour = col_black;
        end
        // Bigger dot
        tile_cookie: begin
          if (off_x_q inside {[2:5]} && off_y_q inside {[2:5]}) colour = col_cookie;
          else colour = col_black;
        end
        default: colour = col_black;
      endcase
    end
  end

  always_ff @(posedge vga_pix_clk) begin
    if (rst) begin
      r <= '0;
      g <= '0;
      b <= '0;
    end else begin
      r <= colour[11:8];
      g <= colour[7:4];
      b <= colour[3:0];
    end
  end

endmodule

/* source/pacman_game.sv */
`timescale 1ns/100ps

module pacman_game import pacman_pkg::*; #(
  parameter int unsigned start_x = 104,
  parameter int unsigned start_y = 208
) (
  input  logic                  vga_pix_clk,
  input  logic                  rst,
  // Beam from the sync generator
  input  logic                  frame_stb,
  input  logic [coord_w-1:0]    sx,
  input  logic [coord_w-1:0]    sy,
  input  logic                  display_enabled,
  // Buttons
  input  logic                  btn_up,
  input  logic                  btn_down,
  input  logic                  btn_left,
  input  logic                  btn_right,
  // APB
  input  logic                  psel,
  input  logic                  penable,
  input  logic                  pwrite,
  input  logic [apb_addr_w-1:0] paddr,
  input  logic [apb_data_w-1:0] pwdata,
  output logic [apb_data_w-1:0] prdata,
  output logic                  pready,
  output logic                  pslverr,
  // Pixel colour, two cycles after the beam
  output logic [3:0]            r,
  output logic [3:0]            g,
  output logic [3:0]            b
);

  logic [map_addr_w-1:0] beam_addr;
  tile_t                 beam_tile;
  logic [coord_w-1:0]    x_pac;
  logic [coord_w-1:0]    y_pac;
  logic                  ate_candy_stb;
  logic                  ate_cookie_stb;
  logic                  pause;

  // Movement engine to RAM port b
  map_port_if map_port ();

  ////////////////////////////////////////////////////////////
  // Map memory
  tile_map_ram tile_map_ram_inst (
    .vga_pix_clk (vga_pix_clk),
    .rst         (rst),
    .beam_addr   (beam_addr),
    .beam_tile   (beam_tile),
    .player      (map_port)
  );

  pacman_movement #(
    .start_x (start_x),
    .start_y (start_y)
  ) pacman_movement_inst (
    .vga_pix_clk    (vga_pix_clk),
    .rst            (rst),
    .frame_stb      (frame_stb),
    .btn_up         (btn_up),
    .btn_down       (btn_down),
    .btn_left       (btn_left),
    .btn_right      (btn_right),
    .pause          (pause),
    .x_pac          (x_pac),
    .y_pac          (y_pac),
    .ate_candy_stb  (ate_candy_stb),
    .ate_cookie_stb (ate_cookie_stb),
    .map            (map_port)
  );

  // Score, pause and position over APB
  score_regs score_regs_inst (
    .vga_pix_clk    (vga_pix_clk),
    .rst            (rst),
    .psel           (psel),
    .penable        (penable),
    .pwrite         (pwrite),
    .paddr          (paddr),
    .pwdata         (pwdata),
    .prdata         (prdata),
    .pready         (pready),
    .pslverr        (pslverr),
    .x_pac          (x_pac),
    .y_pac          (y_pac),
    .ate_candy_stb  (ate_candy_stb),
    .ate_cookie_stb (ate_cookie_stb),
    .pause          (pause)
  );

  ////////////////////////////////////////////////////////////
  // Beam pipeline
  tile_renderer tile_renderer_inst (
    .vga_pix_clk     (vga_pix_clk),
    .rst             (rst),
    .sx              (sx),
    .sy              (sy),
    .display_enabled (display_enabled),
    .x_pac           (x_pac),
    .y_pac           (y_pac),
    .beam_addr       (beam_addr),
    .beam_tile       (beam_tile),
    .r               (r),
    .g               (g),
    .b               (b)
  );

endmodule

/* testbench/tb_pacman_game.sv */
`timescale 1ns/100ps

module tb_pacman_game import pacman_pkg::*; ();

  // Start position as set on the DUT
  localparam int start_x = 104;
  localparam int start_y = 208;
  // About 300 frames of 16 cycles, render sweeps and APB, with margin
  localparam int cycle_limit = 20000;

  logic                  vga_pix_clk;
  logic                  rst;
  logic                  frame_stb;
  logic [coord_w-1:0]    sx;
  logic [coord_w-1:0]    sy;
  logic                  display_enabled;
  logic                  btn_up;
  logic                  btn_down;
  logic                  btn_left;
  logic                  btn_right;
  logic                  psel;
  logic                  penable;
  logic                  pwrite;
  logic [apb_addr_w-1:0] paddr;
  logic [apb_data_w-1:0] pwdata;
  logic [apb_data_w-1:0] prdata;
  logic                  pready;
  logic                  pslverr;
  logic [3:0]            r;
  logic [3:0]            g;
  logic [3:0]            b;

  // Expected game state
  tile_t exp_map [map_rows][map_cols];
  int    tb_x = start_x;
  int    tb_y = start_y;
  int    exp_score = 0;
  int    exp_cookies = 0;
  int    cycle_cnt = 0;

  // Expected colour, delayed to line up with the render pipeline
  logic        render_check = 1'b0;
  logic        render_q1 = 1'b0;
  logic        render_q2 = 1'b0;
  logic        off_q1 = 1'b0;
  logic        off_q2 = 1'b0;
  logic [11:0] colour_q1 = '0;
  logic [11:0] colour_q2 = '0;

  pacman_game #(
    .start_x (start_x),
    .start_y (start_y)
  ) pacman_game_inst (
    .vga_pix_clk     (vga_pix_clk),
    .rst             (rst),
    .frame_stb       (frame_stb),
    .sx              (sx),
    .sy              (sy),
    .display_enabled (display_enabled),
    .btn_up          (btn_up),
    .btn_down        (btn_down),
    .btn_left        (btn_left),
    .btn_right       (btn_right),
    .psel            (psel),
    .penable         (penable),
    .pwrite          (pwrite),
    .paddr           (paddr),
    .pwdata          (pwdata),
    .prdata          (prdata),
    .pready          (pready),
    .pslverr         (pslverr),
    .r               (r),
    .g               (g),
    .b               (b)
  );

  initial begin
    vga_pix_clk = 1'b0;
    forever #5 vga_pix_clk = ~vga_pix_clk;
  end

  ////////////////////////////////////////////////////////////
  // Failure reporting
  task automatic stop_failed();
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  task automatic report_error(input string msg);
    $display("error %0t: %s", $time, msg);
    stop_failed();
  endtask

  always @(posedge vga_pix_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("timeout after %0d cycles, the test sequence did not finish", cycle_limit);
      stop_failed();
    end
  end

  ////////////////////////////////////////////////////////////
  // Reference colour of one beam pixel
  function automatic logic [11:0] pixel_colour(input int px, input int py, input logic en);
    int    col;
    int    row;
    int    ox;
    int    oy;
    tile_t t;
    col = px / tile_size;
    row = py / tile_size;
    ox  = px % tile_size;
    oy  = py % tile_size;
    if (!en) return col_black;
    // Solid player square wins over tiles
    if (px >= tb_x && px < tb_x + tile_size && py >= tb_y && py < tb_y + tile_size) begin
      return col_player;
    end
    if (col >= vis_cols || row >= map_rows) return col_black;
    t = exp_map[row][col];
    if (t == tile_wall) return col_wall;
    if (t == tile_candy && ox >= 3 && ox <= 4 && oy >= 3 && oy <= 4) return col_candy;
    if (t == tile_cookie && ox >= 2 && ox <= 5 && oy >= 2 && oy <= 5) return col_cookie;
    return col_black;
  endfunction

  // Two cycles from beam to rgb
  always @(posedge vga_pix_clk) begin
    colour_q1 <= pixel_colour(sx, sy, display_enabled);
    colour_q2 <= colour_q1;
    render_q1 <= render_check;
    render_q2 <= render_q1;
    off_q1    <= !display_enabled;
    off_q2    <= off_q1;
  end

  ////////////////////////////////////////////////////////////
  // Checks
  a_black_when_off: assert property (
    @(posedge vga_pix_clk) disable iff (rst) off_q2 |-> ({r, g, b} == 12'h000)
  ) else report_error($sformatf("rgb %h while display disabled", $sampled({r, g, b})));

  a_render_colour: assert property (
    @(posedge vga_pix_clk) disable iff (rst) render_q2 |-> ({r, g, b} == colour_q2)
  ) else report_error($sformatf("pixel colour %h, expected %h",
                                $sampled({r, g, b}), $sampled(colour_q2)));

  a_pready_in_access: assert property (
    @(posedge vga_pix_clk) disable iff (rst) (psel && penable) |-> pready
  ) else report_error("pready low in an APB access phase");

  a_no_err_outside_access: assert property (
    @(posedge vga_pix_clk) disable iff (rst) !(psel && penable) |-> !pslverr
  ) else report_error("pslverr high outside an APB access phase");

  ////////////////////////////////////////////////////////////
  // Stimulus helpers
  task automatic tick();
    @(posedge vga_pix_clk);
    #1;
  endtask

  // One frame strobe, then the rest of a 16 cycle frame
  task automatic step_frame();
    frame_stb = 1'b1;
    tick();
    frame_stb = 1'b0;
    repeat (15) tick();
  endtask

  task automatic read_reg(input logic [apb_addr_w-1:0] addr,
                          input logic [apb_data_w-1:0] exp_data, input logic exp_err);
    logic [apb_data_w-1:0] data;
    logic                  err;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    tick();
    penable = 1'b1;
    // Mid cycle, access phase outputs settled
    @(negedge vga_pix_clk);
    data = prdata;
    err  = pslverr;
    tick();
    psel    = 1'b0;
    penable = 1'b0;
    assert (err == exp_err)
      else report_error($sformatf("read at %0d pslverr %b, expected %b", addr, err, exp_err));
    if (!exp_err) begin
      assert (data == exp_data)
        else report_error($sformatf("read at %0d returned %h, expected %h",
                                    addr, data, exp_data));
    end
  endtask

  task automatic write_reg(input logic [apb_addr_w-1:0] addr,
                           input logic [apb_data_w-1:0] data, input logic exp_err);
    logic err;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    tick();
    penable = 1'b1;
    @(negedge vga_pix_clk);
    err = pslverr;
    tick();
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    assert (err == exp_err)
      else report_error($sformatf("write at %0d pslverr %b, expected %b", addr, err, exp_err));
  endtask

  // One frame of expected movement in direction dx, dy
  task automatic advance_model(input int dx, input int dy);
    tile_t ahead;
    ahead = exp_map[tb_y / tile_size + dy][tb_x / tile_size + dx];
    if (tb_x % tile_size != 0 || tb_y % tile_size != 0 || ahead != tile_wall) begin
      tb_x = tb_x + dx;
      tb_y = tb_y + dy;
      // Landing on a tile eats what lies there
      if (tb_x % tile_size == 0 && tb_y % tile_size == 0) begin
        case (exp_map[tb_y / tile_size][tb_x / tile_size])
          tile_candy:  exp_score = exp_score + 1;
          tile_cookie: exp_cookies = exp_cookies + 1;
          default:     ;
        endcase
        if (exp_map[tb_y / tile_size][tb_x / tile_size] != tile_wall) begin
          exp_map[tb_y / tile_size][tb_x / tile_size] = tile_empty;
        end
      end
    end
  endtask

  task automatic check_position();
    read_reg(reg_position, apb_data_w'((tb_y << 16) | tb_x), 1'b0);
  endtask

  // Beam over a block of tiles, every pixel checked
  task automatic sweep_tiles(input int col0, input int row0, input int ncols, input int nrows);
    for (int py = row0 * tile_size; py < (row0 + nrows) * tile_size; py++) begin
      for (int px = col0 * tile_size; px < (col0 + ncols) * tile_size; px++) begin
        sx              = coord_w'(px);
        sy              = coord_w'(py);
        display_enabled = 1'b1;
        render_check    = 1'b1;
        tick();
      end
    end
    display_enabled = 1'b0;
    render_check    = 1'b0;
    tick();
    tick();
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequence
  initial begin
    rst             = 1'b1;
    frame_stb       = 1'b0;
    sx              = '0;
    sy              = '0;
    display_enabled = 1'b0;
    btn_up          = 1'b0;
    btn_down        = 1'b0;
    btn_left        = 1'b0;
    btn_right       = 1'b0;
    psel            = 1'b0;
    penable         = 1'b0;
    pwrite          = 1'b0;
    paddr           = '0;
    pwdata          = '0;
    for (int row = 0; row < map_rows; row++) begin
      for (int col = 0; col < map_cols; col++) begin
        exp_map[row][col] = initial_tile(col, row);
      end
    end
    repeat (16) @(posedge vga_pix_clk);
    #1;
    rst = 1'b0;
    tick();

    // Reset state
    check_position();
    read_reg(reg_score, 32'd0, 1'b0);
    read_reg(reg_cookies, 32'd0, 1'b0);
    read_reg(reg_ctrl, 32'd0, 1'b0);

    // Walls, cookie corner, player and the hidden columns
    sweep_tiles(0, 0, 4, 3);
    sweep_tiles(12, 25, 4, 3);
    sweep_tiles(26, 0, 4, 2);

    // Left along row 26 into the border
    btn_left = 1'b1;
    repeat (100) begin
      step_frame();
      advance_model(-1, 0);
      check_position();
    end
    btn_left = 1'b0;
    read_reg(reg_score, apb_data_w'(exp_score), 1'b0);

    // Up column 1 to the cookie corner
    btn_up = 1'b1;
    repeat (204) begin
      step_frame();
      advance_model(0, -1);
      check_position();
    end
    btn_up = 1'b0;
    read_reg(reg_score, apb_data_w'(exp_score), 1'b0);
    read_reg(reg_cookies, apb_data_w'(exp_cookies), 1'b0);

    // Eaten tiles now dark
    sweep_tiles(0, 0, 4, 4);
    sweep_tiles(0, 25, 14, 2);

    // Paused, frames must not move the player
    write_reg(reg_ctrl, 32'd1, 1'b0);
    read_reg(reg_ctrl, 32'd1, 1'b0);
    btn_right = 1'b1;
    repeat (10) begin
      step_frame();
      check_position();
    end
    write_reg(reg_ctrl, 32'd0, 1'b0);
    read_reg(reg_ctrl, 32'd0, 1'b0);
    repeat (10) begin
      step_frame();
      advance_model(1, 0);
      check_position();
    end
    btn_right = 1'b0;
    read_reg(reg_score, apb_data_w'(exp_score), 1'b0);

    // Bus errors leave state alone
    write_reg(reg_score, 32'h3ff, 1'b1);
    read_reg(reg_score, apb_data_w'(exp_score), 1'b0);
    read_reg(4'd2, 32'd0, 1'b1);
    write_reg(reg_position, 32'd0, 1'b1);
    check_position();

    tick();
    $display("PASS: all tests");
    $finish;
  end

endmodule

/* compile.f */
source/pacman_pkg.sv
source/map_port_if.sv
source/tile_map_ram.sv
source/pacman_movement.sv
source/score_regs.sv
source/tile_renderer.sv
source/pacman_game.sv
testbench/tb_pacman_game.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the pacman_game testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f compile.f \
  --top-module tb_pacman_game -o sim_tb_pacman_game > build.log 2>&1 \
  || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/sim_tb_pacman_game > sim.log 2>&1
cat sim.log

grep -q "FAIL: see errors above" sim.log && { echo "simulation failed"; exit 1; }
grep -q "PASS: all tests" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"
